// File: list.f
+incdir+source
source/core_pkg.sv
source/fetch_if.sv
source/core_alu.sv
source/core_regfile.sv
source/core_fetch_stage.sv
source/core_id_stage.sv
source/core_top.sv
tb/core_assertions.sv
tb/core_tb.sv

// File: source/core_alu.sv
/*
 * Combinational ALU. Shifts use operand_b_i[4:0] only.
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module core_alu (
  input  core_pkg::alu_op_e operator_i,
  input  core_pkg::word_t   operand_a_i,
  input  core_pkg::word_t   operand_b_i,
  output core_pkg::word_t   result_o,
  output logic              equal_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal_o     = operand_a_i == operand_b_i;

  always_comb begin
    case (operator_i)
      core_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      core_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      core_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      core_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      core_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      core_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      core_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      core_pkg::ALU_SRA:  result_o = core_pkg::word_t'($signed(operand_a_i) >>> shamt);
      core_pkg::ALU_SLT:  result_o = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
      core_pkg::ALU_SLTU: result_o = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
      core_pkg::ALU_EQ:   result_o = {{(`CORE_XLEN-1){1'b0}}, equal_o};
      default:            result_o = '0;
    endcase
  end

endmodule

// File: source/core_defs.svh
/*
 * Widths and major opcode values fixed by the RV32I base ISA.
 * Only the opcodes of the supported subset are listed.
 */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and register file
`define CORE_XLEN     32
`define CORE_NUM_REGS 32
`define CORE_REG_AW   5

////////////////////////////////////////////////////////////
// Major opcodes, instr[6:0]
////////////////////////////////////////////////////////////
`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_OP_IMM 7'b0010011
`define CORE_OPC_LUI    7'b0110111
`define CORE_OPC_JAL    7'b1101111
`define CORE_OPC_BRANCH 7'b1100011

`endif

// File: source/core_fetch_stage.sv
/*
 * One instruction bus request outstanding at a time, no bus error input.
 * A redirect while a response is still due drops that response.
 */
`timescale 1ns/10ps

module core_fetch_stage (
  input  logic            clk,
  input  logic            rst_ni,
  input  core_pkg::word_t boot_addr_i,
  input  logic            fetch_enable_i,
  output logic            instr_req_o,
  output core_pkg::word_t instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  core_pkg::word_t instr_rdata_i,
  fetch_if.fetch          fetch_o
);

  core_pkg::fetch_state_e state_q;
  core_pkg::fetch_state_e state_d;
  core_pkg::word_t        pc_q;
  core_pkg::word_t        pc_d;
  core_pkg::word_t        addr_q;
  logic                   started_q;
  logic                   discard_q;
  logic                   discard_d;
  logic                   valid_q;
  logic                   valid_d;
  core_pkg::word_t        instr_q;
  core_pkg::word_t        instr_pc_q;
  core_pkg::word_t        fetch_pc;
  logic                   issue;
  logic                   gnt_fire;
  logic                   load;

  // Boot address is used directly until the first request
  assign fetch_pc = started_q ? pc_q : boot_addr_i;

  // Holding register must be free by the time the word returns
  assign issue = (state_q == core_pkg::FETCH_IDLE) && (started_q || fetch_enable_i) &&
                 (!valid_q || fetch_o.ready);

  assign instr_req_o  = issue || (state_q == core_pkg::FETCH_WAIT_GNT);
  assign instr_addr_o = (state_q == core_pkg::FETCH_IDLE) ? fetch_pc : addr_q;
  assign gnt_fire     = instr_req_o && instr_gnt_i;
  assign load = (state_q == core_pkg::FETCH_WAIT_RVALID) && instr_rvalid_i && !discard_q;

  ////////////////////////////////////////////////////////////
  // Bus FSM and next PC
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d   = state_q;
    pc_d      = pc_q;
    discard_d = discard_q;
    valid_d   = valid_q;

    case (state_q)
      core_pkg::FETCH_IDLE: begin
        if (issue) begin
          state_d = instr_gnt_i ? core_pkg::FETCH_WAIT_RVALID : core_pkg::FETCH_WAIT_GNT;
        end
      end
      core_pkg::FETCH_WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_d = core_pkg::FETCH_WAIT_RVALID;
        end
      end
      core_pkg::FETCH_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_d   = core_pkg::FETCH_IDLE;
          discard_d = 1'b0;
        end
      end
      default: begin
        state_d = core_pkg::FETCH_IDLE;
      end
    endcase

    // A stale request must not move the PC
    if (gnt_fire && !discard_q) begin
      pc_d = instr_addr_o + 'd4;
    end

    if (valid_q && fetch_o.ready) begin
      valid_d = 1'b0;
    end
    if (load) begin
      valid_d = 1'b1;
    end

    // Taken branch or JAL in decode
    if (fetch_o.redirect) begin
      pc_d    = fetch_o.redirect_pc;
      valid_d = 1'b0;
      if (state_d != core_pkg::FETCH_IDLE) begin
        discard_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= core_pkg::FETCH_IDLE;
      pc_q      <= '0;
      started_q <= 1'b0;
      discard_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      pc_q      <= pc_d;
      started_q <= started_q | issue;
      discard_q <= discard_d;
      valid_q   <= valid_d;
    end
  end

  // Request address and held instruction
  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q <= fetch_pc;
    end
    if (load) begin
      instr_q    <= instr_rdata_i;
      instr_pc_q <= addr_q;
    end
  end

  assign fetch_o.valid = valid_q;
  assign fetch_o.instr = instr_q;
  assign fetch_o.pc    = instr_pc_q;

endmodule

// File: source/core_id_stage.sv
/*
 * Single-cycle decode and execute, ready is always high.
 * Illegal words retire with the trap flag and write nothing. No handler.
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module core_id_stage (
  input  logic                clk,
  input  logic                rst_ni,
  fetch_if.decode             fetch_i,
  output logic                retire_valid_o,
  output core_pkg::word_t     retire_pc_o,
  output core_pkg::word_t     retire_insn_o,
  output core_pkg::reg_addr_t retire_rd_addr_o,
  output core_pkg::word_t     retire_rd_wdata_o,
  output logic                retire_trap_o
);

  core_pkg::word_t     instr;
  core_pkg::opcode_e   opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::reg_addr_t rd;
  core_pkg::word_t     imm_i;
  core_pkg::word_t     imm_u;
  core_pkg::word_t     imm_b;
  core_pkg::word_t     imm_j;
  core_pkg::alu_op_e   alu_op;
  logic                use_imm;
  logic                rd_we;
  logic                is_lui;
  logic                is_jal;
  logic                is_branch;
  logic                illegal;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  core_pkg::word_t     alu_result;
  logic                alu_equal;
  core_pkg::word_t     rd_wdata;
  logic                rd_write;
  logic                branch_taken;
  logic                fire;

  assign instr  = fetch_i.instr;
  assign opcode = core_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{(`CORE_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{(`CORE_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////
  always_comb begin
    alu_op    = core_pkg::ALU_ADD;
    use_imm   = 1'b0;
    rd_we     = 1'b0;
    is_lui    = 1'b0;
    is_jal    = 1'b0;
    is_branch = 1'b0;
    illegal   = 1'b0;

    case (opcode)
      core_pkg::OPC_OP: begin
        rd_we = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = core_pkg::ALU_SUB;
          {7'b0000000, 3'b001}: alu_op = core_pkg::ALU_SLL;
          {7'b0000000, 3'b010}: alu_op = core_pkg::ALU_SLT;
          {7'b0000000, 3'b011}: alu_op = core_pkg::ALU_SLTU;
          {7'b0000000, 3'b100}: alu_op = core_pkg::ALU_XOR;
          {7'b0000000, 3'b101}: alu_op = core_pkg::ALU_SRL;
          {7'b0100000, 3'b101}: alu_op = core_pkg::ALU_SRA;
          {7'b0000000, 3'b110}: alu_op = core_pkg::ALU_OR;
          {7'b0000000, 3'b111}: alu_op = core_pkg::ALU_AND;
          default:              illegal = 1'b1;
        endcase
      end
      core_pkg::OPC_OP_IMM: begin
        rd_we   = 1'b1;
        use_imm = 1'b1;
        case (funct3)
          3'b000:  alu_op = core_pkg::ALU_ADD;
          3'b010:  alu_op = core_pkg::ALU_SLT;
          3'b011:  alu_op = core_pkg::ALU_SLTU;
          3'b100:  alu_op = core_pkg::ALU_XOR;
          3'b110:  alu_op = core_pkg::ALU_OR;
          3'b111:  alu_op = core_pkg::ALU_AND;
          3'b001:  begin
            alu_op  = core_pkg::ALU_SLL;
            illegal = funct7 != 7'b0000000;
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            alu_op  = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      core_pkg::OPC_LUI: begin
        rd_we  = 1'b1;
        is_lui = 1'b1;
      end
      core_pkg::OPC_JAL: begin
        rd_we  = 1'b1;
        is_jal = 1'b1;
      end
      core_pkg::OPC_BRANCH: begin
        alu_op    = core_pkg::ALU_EQ;
        is_branch = 1'b1;
        // BEQ and BNE only
        illegal   = funct3[2:1] != 2'b00;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    if (illegal) begin
      rd_we     = 1'b0;
      is_jal    = 1'b0;
      is_branch = 1'b0;
    end
  end

  core_regfile i_regfile (
    .clk       ( clk            ),
    .rst_ni    ( rst_ni         ),
    .raddr_a_i ( rs1            ),
    .raddr_b_i ( rs2            ),
    .rdata_a_o ( rs1_data       ),
    .rdata_b_o ( rs2_data       ),
    .waddr_i   ( rd             ),
    .wdata_i   ( rd_wdata       ),
    .we_i      ( fire && rd_we  )
  );

  core_alu i_alu (
    .operator_i  ( alu_op                       ),
    .operand_a_i ( rs1_data                     ),
    .operand_b_i ( use_imm ? imm_i : rs2_data   ),
    .result_o    ( alu_result                   ),
    .equal_o     ( alu_equal                    )
  );

  ////////////////////////////////////////////////////////////
  // Write-back and redirect
  ////////////////////////////////////////////////////////////
  assign fire     = fetch_i.valid && fetch_i.ready;
  assign rd_write = rd_we && (rd != '0);

  always_comb begin
    if (is_lui) begin
      rd_wdata = imm_u;
    end else if (is_jal) begin
      rd_wdata = fetch_i.pc + 'd4;
    end else begin
      rd_wdata = alu_result;
    end
  end

  // funct3[0] set means BNE
  assign branch_taken = is_branch && (funct3[0] ? !alu_equal : alu_equal);

  assign fetch_i.ready       = 1'b1;
  assign fetch_i.redirect    = fire && (is_jal || branch_taken);
  assign fetch_i.redirect_pc = fetch_i.pc + (is_jal ? imm_j : imm_b);

  // Retirement record, one clock after the transfer
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_o    <= 1'b0;
      retire_pc_o       <= '0;
      retire_insn_o     <= '0;
      retire_rd_addr_o  <= '0;
      retire_rd_wdata_o <= '0;
      retire_trap_o     <= 1'b0;
    end else begin
      retire_valid_o <= fire;
      if (fire) begin
        retire_pc_o       <= fetch_i.pc;
        retire_insn_o     <= instr;
        retire_rd_addr_o  <= rd_write ? rd : '0;
        retire_rd_wdata_o <= rd_write ? rd_wdata : '0;
        retire_trap_o     <= illegal;
      end
    end
  end

endmodule

// File: source/core_pkg.sv
/*
 * Shared types of the core. Encodings cover the RV32I subset only,
 * so loads, stores and system opcodes decode as illegal.
 */
`include "core_defs.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]   word_t;
  typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

  // Major opcodes kept in the subset
  typedef enum logic [6:0] {
    OPC_OP     = `CORE_OPC_OP,
    OPC_OP_IMM = `CORE_OPC_OP_IMM,
    OPC_LUI    = `CORE_OPC_LUI,
    OPC_JAL    = `CORE_OPC_JAL,
    OPC_BRANCH = `CORE_OPC_BRANCH
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ
  } alu_op_e;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID
  } fetch_state_e;

endpackage

// File: source/core_regfile.sv
/*
 * Flip-flop register file, asynchronous reads. Writes to x0 are ignored.
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module core_regfile (
  input  logic                clk,
  input  logic                rst_ni,
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::word_t     rdata_a_o,
  output core_pkg::word_t     rdata_b_o,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::word_t     wdata_i,
  input  logic                we_i
);

  core_pkg::word_t regs [`CORE_NUM_REGS];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 is never written so it reads zero
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

// File: source/core_top.sv
/*
 * RV32I subset core without loads, stores, CSRs or interrupts.
 * Fetch starts on the first cycle after reset with fetch_enable_i high.
 */
`timescale 1ns/10ps

module core_top (
  input  logic                clk,
  input  logic                rst_ni,
  input  core_pkg::word_t     boot_addr_i,
  input  logic                fetch_enable_i,

  // Instruction bus
  output logic                instr_req_o,
  output core_pkg::word_t     instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  core_pkg::word_t     instr_rdata_i,

  // Retirement record
  output logic                retire_valid_o,
  output core_pkg::word_t     retire_pc_o,
  output core_pkg::word_t     retire_insn_o,
  output core_pkg::reg_addr_t retire_rd_addr_o,
  output core_pkg::word_t     retire_rd_wdata_o,
  output logic                retire_trap_o
);

  fetch_if fetch_link ();

  core_fetch_stage i_fetch_stage (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fetch_o        ( fetch_link     )
  );

  core_id_stage i_id_stage (
    .clk               ( clk               ),
    .rst_ni            ( rst_ni            ),
    .fetch_i           ( fetch_link        ),
    .retire_valid_o    ( retire_valid_o    ),
    .retire_pc_o       ( retire_pc_o       ),
    .retire_insn_o     ( retire_insn_o     ),
    .retire_rd_addr_o  ( retire_rd_addr_o  ),
    .retire_rd_wdata_o ( retire_rd_wdata_o ),
    .retire_trap_o     ( retire_trap_o     )
  );

endmodule

// File: source/fetch_if.sv
/*
 * Fetch to decode link. Redirect is only valid in a transfer cycle.
 */
`timescale 1ns/10ps

interface fetch_if;

  // Driven by fetch
  logic            valid;
  core_pkg::word_t instr;
  core_pkg::word_t pc;

  // Driven by decode
  logic            ready;
  logic            redirect;
  core_pkg::word_t redirect_pc;

  modport fetch (
    output valid,
    output instr,
    output pc,
    input  ready,
    input  redirect,
    input  redirect_pc
  );

  modport decode (
    input  valid,
    input  instr,
    input  pc,
    output ready,
    output redirect,
    output redirect_pc
  );

endinterface

// File: tb/core_assertions.sv
/*
 * Bus and retirement protocol checks, bound into core_top.
 * Assumes at most one instruction request outstanding.
 */
`timescale 1ns/10ps

module core_assertions (
  input logic                clk,
  input logic                rst_ni,
  input logic                req_i,
  input core_pkg::word_t     addr_i,
  input logic                gnt_i,
  input logic                rvalid_i,
  input logic                retire_valid_i,
  input core_pkg::reg_addr_t rd_addr_i,
  input core_pkg::word_t     rd_wdata_i
);

  int   fail_count = 0;
  logic outstanding_q;

  // Granted request still waiting for its data
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (req_i && gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  req_stable: assert property (@(posedge clk) disable iff (!rst_ni)
      req_i && !gnt_i |=> req_i && $stable(addr_i))
    else begin
      $error("instruction request dropped or changed before grant");
      fail_count++;
    end

  rvalid_granted: assert property (@(posedge clk) disable iff (!rst_ni)
      rvalid_i |-> outstanding_q)
    else begin
      $error("rvalid without an outstanding grant");
      fail_count++;
    end

  retire_in_reset: assert property (@(posedge clk) !rst_ni |-> !retire_valid_i)
    else begin
      $error("retire_valid_o high during reset");
      fail_count++;
    end

  x0_no_data: assert property (@(posedge clk) disable iff (!rst_ni)
      rd_addr_i == '0 |-> rd_wdata_i == '0)
    else begin
      $error("nonzero write data retired with rd_addr zero");
      fail_count++;
    end

endmodule

bind core_top core_assertions i_assertions (
  .clk            ( clk               ),
  .rst_ni         ( rst_ni            ),
  .req_i          ( instr_req_o       ),
  .addr_i         ( instr_addr_o      ),
  .gnt_i          ( instr_gnt_i       ),
  .rvalid_i       ( instr_rvalid_i    ),
  .retire_valid_i ( retire_valid_o    ),
  .rd_addr_i      ( retire_rd_addr_o  ),
  .rd_wdata_i     ( retire_rd_wdata_o )
);

// File: tb/core_tb.sv
/*
 * Testbench for core_top. A generated RV32I program runs from a word memory
 * with random grant and rvalid delays. Stops at the first mismatch.
 */
`timescale 1ns/10ps
`include "core_defs.svh"

module core_tb;

  localparam core_pkg::word_t BOOT_ADDR  = 32'h0000_0400;
  localparam int              MEM_WORDS  = 128;
  localparam int              RST_CYCLES = 16;
  localparam int              EN_DELAY   = 5;
  localparam int              IDLE_LIMIT = 100;

  typedef struct packed {
    core_pkg::word_t     pc;
    core_pkg::word_t     insn;
    core_pkg::reg_addr_t rd_addr;
    core_pkg::word_t     rd_wdata;
    logic                trap;
  } retire_t;

  logic                clk;
  logic                rst_ni;
  core_pkg::word_t     boot_addr_i;
  logic                fetch_enable_i;
  logic                instr_req_o;
  core_pkg::word_t     instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  core_pkg::word_t     instr_rdata_i;
  logic                retire_valid_o;
  core_pkg::word_t     retire_pc_o;
  core_pkg::word_t     retire_insn_o;
  core_pkg::reg_addr_t retire_rd_addr_o;
  core_pkg::word_t     retire_rd_wdata_o;
  logic                retire_trap_o;

  core_pkg::word_t mem [MEM_WORDS];
  int              n_words;
  core_pkg::word_t end_pc;
  int              cycle_limit;
  logic            run_done;
  core_pkg::word_t lcg_state = 32'hc136cf09;

  // Architectural model state
  core_pkg::word_t m_pc;
  core_pkg::word_t m_regs [`CORE_NUM_REGS];

  // Memory model state
  logic            gnt_waiting;
  logic            rsp_pending;
  logic            first_req_seen;
  int              gnt_wait;
  int              rsp_wait;
  core_pkg::word_t rsp_addr;
  core_pkg::word_t rnd;

  core_top i_dut (
    .clk               ( clk               ),
    .rst_ni            ( rst_ni            ),
    .boot_addr_i       ( boot_addr_i       ),
    .fetch_enable_i    ( fetch_enable_i    ),
    .instr_req_o       ( instr_req_o       ),
    .instr_addr_o      ( instr_addr_o      ),
    .instr_gnt_i       ( instr_gnt_i       ),
    .instr_rvalid_i    ( instr_rvalid_i    ),
    .instr_rdata_i     ( instr_rdata_i     ),
    .retire_valid_o    ( retire_valid_o    ),
    .retire_pc_o       ( retire_pc_o       ),
    .retire_insn_o     ( retire_insn_o     ),
    .retire_rd_addr_o  ( retire_rd_addr_o  ),
    .retire_rd_wdata_o ( retire_rd_wdata_o ),
    .retire_trap_o     ( retire_trap_o     )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic core_pkg::word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Words outside the program read back as their own address
  function automatic core_pkg::word_t read_mem(input core_pkg::word_t addr);
    core_pkg::word_t idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (addr >= BOOT_ADDR && idx < MEM_WORDS) begin
      return mem[idx];
    end
    return addr;
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_word(input string name, input core_pkg::word_t exp,
                            input core_pkg::word_t act);
    if (act !== exp) begin
      report_fail($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_reg_addr(input string name, input core_pkg::reg_addr_t exp,
                                input core_pkg::reg_addr_t act);
    if (act !== exp) begin
      report_fail($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_fail($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Instruction encoding and program
  ////////////////////////////////////////////////////////////
  function automatic core_pkg::word_t op_word(input logic [6:0] f7,
      input core_pkg::reg_addr_t rs2, input core_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input core_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
  endfunction

  function automatic core_pkg::word_t imm_word(input logic [11:0] imm,
      input core_pkg::reg_addr_t rs1, input logic [2:0] f3,
      input core_pkg::reg_addr_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic core_pkg::word_t lui_word(input logic [19:0] imm,
      input core_pkg::reg_addr_t rd);
    return {imm, rd, `CORE_OPC_LUI};
  endfunction

  function automatic core_pkg::word_t branch_word(input logic [12:0] off,
      input core_pkg::reg_addr_t rs2, input core_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `CORE_OPC_BRANCH};
  endfunction

  function automatic core_pkg::word_t jal_word(input logic [20:0] off,
      input core_pkg::reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `CORE_OPC_JAL};
  endfunction

  task automatic emit_word(input core_pkg::word_t w);
    mem[n_words] = w;
    n_words++;
  endtask

  task automatic build_program();
    core_pkg::word_t hi;
    core_pkg::word_t lo;
    core_pkg::word_t imm;
    core_pkg::word_t bump;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = BOOT_ADDR + 4 * i;
    end
    n_words = 0;
    // Random x1 to x4 with x2 negative and x3 positive
    for (int r = 1; r <= 4; r++) begin
      hi = next_rand();
      lo = next_rand();
      if (r == 2) begin
        hi[31] = 1'b1;
      end
      if (r == 3) begin
        hi[31] = 1'b0;
      end
      emit_word(lui_word(hi[31:12], core_pkg::reg_addr_t'(r)));
      emit_word(imm_word(lo[11:0], core_pkg::reg_addr_t'(r), 3'b000,
                         core_pkg::reg_addr_t'(r), `CORE_OPC_OP_IMM));
    end
    // Register-register ops on (x2, x3) and (x3, x4)
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 8; k++) begin
        emit_word(op_word(7'h00, core_pkg::reg_addr_t'(3 + p), core_pkg::reg_addr_t'(2 + p),
                          3'(k), core_pkg::reg_addr_t'(5 + k)));
      end
      emit_word(op_word(7'h20, core_pkg::reg_addr_t'(3 + p), core_pkg::reg_addr_t'(2 + p),
                        3'b000, 5'd13));
      emit_word(op_word(7'h20, core_pkg::reg_addr_t'(3 + p), core_pkg::reg_addr_t'(2 + p),
                        3'b101, 5'd14));
    end
    // Immediate ops where the shifts keep funct7 clear
    for (int k = 0; k < 8; k++) begin
      imm = next_rand();
      if (k == 1 || k == 5) begin
        imm[11:5] = 7'h00;
      end
      emit_word(imm_word(imm[11:0], 5'd2, 3'(k), core_pkg::reg_addr_t'(15 + k),
                         `CORE_OPC_OP_IMM));
    end
    imm = next_rand();
    emit_word(imm_word({7'h20, imm[4:0]}, 5'd2, 3'b101, 5'd23, `CORE_OPC_OP_IMM));
    emit_word(lui_word(imm[31:12], 5'd24));
    emit_word(op_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    // Forward branches where the bump only retires on a fall through
    bump = imm_word(12'd1, 5'd25, 3'b000, 5'd25, `CORE_OPC_OP_IMM);
    emit_word(branch_word(13'd8, 5'd1, 5'd1, 3'b000));
    emit_word(bump);
    emit_word(branch_word(13'd8, 5'd3, 5'd2, 3'b000));
    emit_word(bump);
    emit_word(branch_word(13'd8, 5'd3, 5'd2, 3'b001));
    emit_word(bump);
    emit_word(branch_word(13'd8, 5'd4, 5'd4, 3'b001));
    emit_word(bump);
    emit_word(jal_word(21'd12, 5'd26));
    emit_word(bump);
    emit_word(bump);
    // A load is outside the subset
    emit_word(imm_word(12'h000, 5'd1, 3'b010, 5'd27, 7'b0000011));
    emit_word(op_word(7'h00, 5'd0, 5'd27, 3'b000, 5'd28));
    end_pc = BOOT_ADDR + 4 * n_words;
    emit_word(jal_word(21'd0, 5'd0));
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
      input core_pkg::word_t a, input core_pkg::word_t b);
    core_pkg::word_t r;
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b001:  r = a << b[4:0];
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  r = (a < b) ? 32'd1 : 32'd0;
      3'b100:  r = a ^ b;
      3'b101: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic retire_t step_model();
    retire_t         r;
    core_pkg::word_t insn;
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t res;
    core_pkg::word_t next_pc;
    logic            wr;
    logic            bad;
    logic [2:0]      f3;
    logic [6:0]      f7;
    insn    = read_mem(m_pc);
    f3      = insn[14:12];
    f7      = insn[31:25];
    a       = m_regs[insn[19:15]];
    b       = m_regs[insn[24:20]];
    next_pc = m_pc + 4;
    res     = '0;
    wr      = 1'b0;
    bad     = 1'b0;
    case (insn[6:0])
      `CORE_OPC_OP: begin
        bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        wr  = 1'b1;
        res = alu_ref(f3, f7[5], a, b);
      end
      `CORE_OPC_OP_IMM: begin
        bad = (f3 == 3'b001 && f7 != 7'h00) ||
              (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
        wr  = 1'b1;
        res = alu_ref(f3, f3 == 3'b101 && f7[5], a, {{20{insn[31]}}, insn[31:20]});
      end
      `CORE_OPC_LUI: begin
        wr  = 1'b1;
        res = {insn[31:12], 12'h000};
      end
      `CORE_OPC_JAL: begin
        wr      = 1'b1;
        res     = m_pc + 4;
        next_pc = m_pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      `CORE_OPC_BRANCH: begin
        bad = f3[2:1] != 2'b00;
        if (!bad && ((a == b) != f3[0])) begin
          next_pc = m_pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
        end
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      wr      = 1'b0;
      next_pc = m_pc + 4;
    end
    r.pc   = m_pc;
    r.insn = insn;
    r.trap = bad;
    if (wr && insn[11:7] != 5'd0) begin
      m_regs[insn[11:7]] = res;
      r.rd_addr          = insn[11:7];
      r.rd_wdata         = res;
    end else begin
      r.rd_addr  = '0;
      r.rd_wdata = '0;
    end
    m_pc = next_pc;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // Instruction memory with grant after 0 to 3 cycles and rvalid 1 to 2 later
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      gnt_waiting = 1'b0;
      rsp_pending = 1'b0;
    end else begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      if (instr_req_o && !first_req_seen) begin
        first_req_seen = 1'b1;
        check_word("first request address", BOOT_ADDR, instr_addr_o);
      end
      if (instr_req_o && instr_gnt_i) begin
        gnt_waiting = 1'b0;
        rsp_pending = 1'b1;
        rsp_addr    = instr_addr_o;
        rnd         = next_rand();
        rsp_wait    = int'((rnd >> 16) % 2);
      end else if (instr_req_o) begin
        if (!gnt_waiting) begin
          gnt_waiting = 1'b1;
          rnd         = next_rand();
          gnt_wait    = int'((rnd >> 16) % 4);
        end
        if (gnt_wait == 0) begin
          instr_gnt_i <= 1'b1;
        end else begin
          gnt_wait--;
        end
      end
      if (rsp_pending) begin
        if (rsp_wait == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= read_mem(rsp_addr);
          rsp_pending = 1'b0;
        end else begin
          rsp_wait--;
        end
      end
    end
  end

  // Compare each retirement with the next model step
  initial begin : compare
    retire_t exp;
    int      n;
    n    = 0;
    m_pc = BOOT_ADDR;
    for (int i = 0; i < `CORE_NUM_REGS; i++) begin
      m_regs[i] = '0;
    end
    forever begin
      @(posedge clk);
      if (retire_valid_o) begin
        exp = step_model();
        check_word($sformatf("retire %0d pc", n), exp.pc, retire_pc_o);
        check_word($sformatf("retire %0d insn", n), exp.insn, retire_insn_o);
        check_reg_addr($sformatf("retire %0d rd_addr", n), exp.rd_addr, retire_rd_addr_o);
        check_word($sformatf("retire %0d rd_wdata", n), exp.rd_wdata, retire_rd_wdata_o);
        check_bit($sformatf("retire %0d trap", n), exp.trap, retire_trap_o);
        n++;
        if (exp.pc == end_pc) begin
          run_done = 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    int idle;
    cycles = 0;
    idle   = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (fetch_enable_i && !retire_valid_o) begin
        idle++;
      end else begin
        idle = 0;
      end
      if (cycles > cycle_limit) begin
        report_fail("Timeout: the program did not finish within the cycle limit");
      end
      if (idle > IDLE_LIMIT) begin
        report_fail("Timeout: no instruction retired for 100 cycles");
      end
      if (i_dut.i_assertions.fail_count != 0) begin
        report_fail("A bus or retirement protocol assertion failed during the run");
      end
    end
  end

  initial begin
    rst_ni         = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    first_req_seen = 1'b0;
    run_done       = 1'b0;
    build_program();
    cycle_limit = RST_CYCLES + EN_DELAY + 8 * n_words + IDLE_LIMIT;
    repeat (RST_CYCLES) @(posedge clk);
    rst_ni <= 1'b1;
    // Core stays quiet until enabled
    repeat (EN_DELAY) begin
      @(posedge clk);
      check_bit("request before enable", 1'b0, instr_req_o);
      check_bit("retire before enable", 1'b0, retire_valid_o);
    end
    fetch_enable_i <= 1'b1;
    wait (run_done);
    @(negedge clk);
    if (i_dut.i_assertions.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      report_fail("A bus or retirement protocol assertion failed during the run");
    end
  end

endmodule
